// ==== Bender.yml ====
package:
  name: mmu

sources:
  - mmu_pkg.sv
  - mmu_req_decode.sv
  - mmu_tlb.sv
  - mmu_table_walk.sv
  - mmu_access_check.sv
  - mmu_top.sv
  - target: test
    files:
      - tb_mmu_mem.sv
      - tb_mmu.sv

// ==== flist.f ====
mmu_pkg.sv
mmu_req_decode.sv
mmu_tlb.sv
mmu_table_walk.sv
mmu_access_check.sv
mmu_top.sv
tb_mmu_mem.sv
tb_mmu.sv

// ==== mmu_access_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module mmu_access_check (
	input  wire                              clk,
	input  wire                              rst,
	input  wire                              hit_i,
	input  wire  [mmu_pkg::PPN_W-1:0]        ppn_i,
	input  wire  [mmu_pkg::FLAG_W-1:0]       flags_i,
	input  wire                              fault_i,
	input  wire  mmu_pkg::acc_kind_e         kind_i,
	input  wire  [mmu_pkg::OL_W-1:0]         ol_i,
	input  wire  [mmu_pkg::PAGE_OFS_W-1:0]   ofs_i,
	input  wire                              stb_i,
	output logic                             ack_o,
	output logic                             busy_o,
	output logic [mmu_pkg::VADDR_W-1:0]      padr_o,
	output logic                             cac_o,
	output logic                             page_fault_o,
	output logic                             prv_o,
	output logic                             exv_o,
	output logic                             rdv_o,
	output logic                             wrv_o
);

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_o        <= 1'b0;
			busy_o       <= 1'b0;
			page_fault_o <= 1'b0;
			prv_o        <= 1'b0;
			exv_o        <= 1'b0;
			rdv_o        <= 1'b0;
			wrv_o        <= 1'b0;
		end else begin
			busy_o <= stb_i;	// drops together with ack
			if (!stb_i)
				ack_o <= 1'b0;	// release once cpu lets go
			else if (hit_i || fault_i)
				ack_o <= 1'b1;
			if (fault_i) begin
				page_fault_o <= 1'b1;
				prv_o        <= 1'b0;
				exv_o        <= 1'b0;
				rdv_o        <= 1'b0;
				wrv_o        <= 1'b0;
			end else if (hit_i) begin
				page_fault_o <= 1'b0;
				prv_o <= ol_i != mmu_pkg::OL_SUPER && !flags_i[mmu_pkg::FL_U];
				exv_o <= kind_i == mmu_pkg::ACC_FETCH && !flags_i[mmu_pkg::FL_X];
				rdv_o <= kind_i == mmu_pkg::ACC_READ && !flags_i[mmu_pkg::FL_R];
				wrv_o <= kind_i == mmu_pkg::ACC_WRITE && !flags_i[mmu_pkg::FL_W];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fault_i) begin
			padr_o <= '0;
			cac_o  <= 1'b0;
		end else if (hit_i) begin
			padr_o <= {ppn_i, ofs_i};	// page number joined to offset
			cac_o  <= flags_i[mmu_pkg::FL_C];
		end
	end

endmodule

`default_nettype wire

// ==== mmu_pkg.sv ====
`default_nettype none

package mmu_pkg;

	localparam int VADDR_W    = 32;
	localparam int PAGE_OFS_W = 12;	// 4 KiB pages
	localparam int IDX_W      = 10;	// per table level
	localparam int ASID_W     = 8;
	localparam int PPN_W      = 20;
	localparam int VPN_W      = VADDR_W - PAGE_OFS_W;

	localparam int OL_W = 3;
	localparam logic [OL_W-1:0] OL_SUPER = 3'd0;	// lowest operating level

	// leaf flags as held in the buffer, same order as in the table word
	localparam int FLAG_W = 5;
	localparam int FL_R   = 0;
	localparam int FL_W   = 1;
	localparam int FL_X   = 2;
	localparam int FL_U   = 3;
	localparam int FL_C   = 4;

	typedef enum logic [1:0] {
		ACC_READ  = 2'd0,
		ACC_WRITE = 2'd1,
		ACC_FETCH = 2'd2
	} acc_kind_e;

	// one table word, read as leaf or as pointer to the next table
	typedef union packed {
		struct packed {
			logic [PPN_W-1:0] ppn;
			logic [4:0]       rsv;
			logic             c;
			logic             u;
			logic             x;
			logic             w;
			logic             r;
			logic             is_leaf;
			logic             valid;
		} leaf;
		struct packed {
			logic [PPN_W-1:0] ptn;	// next table page
			logic [9:0]       rsv;
			logic             is_leaf;
			logic             valid;
		} dir;
	} pte_u;

endpackage

`default_nettype wire

// ==== mmu_req_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module mmu_req_decode (
	input  wire                                clk,
	input  wire                                rst,
	input  wire                                cyc_i,
	input  wire                                stb_i,
	input  wire                                we_i,
	input  wire                                icl_i,
	input  wire  [mmu_pkg::VADDR_W-1:0]        vadr_i,
	input  wire  [mmu_pkg::ASID_W-1:0]         asid_i,
	input  wire                                busy_i,
	output logic                               req_valid_o,
	output logic [mmu_pkg::VPN_W-1:0]          req_vpn_o,
	output logic [mmu_pkg::ASID_W-1:0]         req_asid_o,
	output mmu_pkg::acc_kind_e                 req_kind_o
);

	logic accept;

	// busy lags the strobe by one cycle, so this is the rising strobe
	assign accept = cyc_i && stb_i && !busy_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			req_valid_o <= 1'b0;
		end else begin
			req_valid_o <= accept;	// single cycle pulse
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_vpn_o  <= vadr_i[mmu_pkg::VADDR_W-1:mmu_pkg::PAGE_OFS_W];
			req_asid_o <= asid_i;
			if (icl_i)
				req_kind_o <= mmu_pkg::ACC_FETCH;	// fetch wins over write
			else if (we_i)
				req_kind_o <= mmu_pkg::ACC_WRITE;
			else
				req_kind_o <= mmu_pkg::ACC_READ;
		end
	end

	// the checker must already hold busy while the request is presented
	a_busy_after_accept: assert property (
		@(posedge clk) disable iff (rst)
		req_valid_o |-> busy_i
	);

endmodule

`default_nettype wire

// ==== mmu_table_walk.sv ====
`timescale 1ns/10ps
`default_nettype none

module mmu_table_walk #(
	parameter int WALK_TIMEOUT = 255
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          miss_i,
	input  wire  [mmu_pkg::VPN_W-1:0]    vpn_i,
	input  wire  [mmu_pkg::VADDR_W-1:0]  pta_i,
	input  wire                          mem_ack_i,
	input  wire  [31:0]                  mem_dat_i,
	output logic                         mem_cyc_o,
	output logic                         mem_stb_o,
	output logic [mmu_pkg::VADDR_W-1:0]  mem_adr_o,
	output logic                         fill_o,
	output logic [mmu_pkg::PPN_W-1:0]    fill_ppn_o,
	output logic [mmu_pkg::FLAG_W-1:0]   fill_flags_o,
	output logic                         fault_o
);

	localparam int TMR_W = $clog2(WALK_TIMEOUT + 2);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_DIR  = 2'd1;	// first level read
	localparam logic [1:0] ST_GAP  = 2'd2;	// strobe low between reads
	localparam logic [1:0] ST_LEAF = 2'd3;	// second level read

	logic [1:0]                 state_q;
	logic [TMR_W-1:0]           tmr_q;
	logic [mmu_pkg::VPN_W-1:0]  vpn_q;
	mmu_pkg::pte_u              pte;
	logic                       timeout;

	assign pte     = mem_dat_i;
	assign timeout = tmr_q == TMR_W'(WALK_TIMEOUT);

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q   <= ST_IDLE;
			tmr_q     <= '0;
			mem_cyc_o <= 1'b0;
			mem_stb_o <= 1'b0;
			fill_o    <= 1'b0;
			fault_o   <= 1'b0;
		end else begin
			fill_o  <= 1'b0;
			fault_o <= 1'b0;
			case (state_q)
			ST_IDLE:
				if (miss_i) begin
					mem_cyc_o <= 1'b1;
					mem_stb_o <= 1'b1;
					tmr_q     <= '0;
					state_q   <= ST_DIR;
				end
			ST_DIR:
				if (mem_ack_i) begin
					mem_stb_o <= 1'b0;
					if (pte.dir.valid && !pte.dir.is_leaf) begin
						state_q <= ST_GAP;
					end else begin
						mem_cyc_o <= 1'b0;	// invalid or superpage leaf
						fault_o   <= 1'b1;
						state_q   <= ST_IDLE;
					end
				end else if (timeout) begin
					mem_cyc_o <= 1'b0;
					mem_stb_o <= 1'b0;
					fault_o   <= 1'b1;
					state_q   <= ST_IDLE;
				end else begin
					tmr_q <= tmr_q + 1'b1;
				end
			ST_GAP: begin
				mem_stb_o <= 1'b1;
				tmr_q     <= '0;
				state_q   <= ST_LEAF;
			end
			default:
				if (mem_ack_i || timeout) begin
					mem_cyc_o <= 1'b0;
					mem_stb_o <= 1'b0;
					fill_o    <= mem_ack_i && pte.leaf.valid && pte.leaf.is_leaf;
					fault_o   <= !(mem_ack_i && pte.leaf.valid && pte.leaf.is_leaf);
					state_q   <= ST_IDLE;
				end else begin
					tmr_q <= tmr_q + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == ST_IDLE && miss_i) begin
			vpn_q     <= vpn_i;
			mem_adr_o <= pta_i
				+ mmu_pkg::VADDR_W'({vpn_i[mmu_pkg::VPN_W-1 -: mmu_pkg::IDX_W], 2'b00});
		end
		if (state_q == ST_DIR && mem_ack_i)
			mem_adr_o <= {pte.dir.ptn, vpn_q[mmu_pkg::IDX_W-1:0], 2'b00};
		if (state_q == ST_LEAF && mem_ack_i) begin
			fill_ppn_o   <= pte.leaf.ppn;
			fill_flags_o <= {pte.leaf.c, pte.leaf.u, pte.leaf.x, pte.leaf.w, pte.leaf.r};
		end
	end

	a_stb_within_cyc: assert property (
		@(posedge clk) disable iff (rst)
		$rose(mem_stb_o) |-> mem_cyc_o
	);

endmodule

`default_nettype wire

// ==== mmu_tlb.sv ====
`timescale 1ns/10ps
`default_nettype none

module mmu_tlb #(
	parameter int TLB_ENTRIES = 8
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          req_valid_i,
	input  wire  [mmu_pkg::VPN_W-1:0]    req_vpn_i,
	input  wire  [mmu_pkg::ASID_W-1:0]   req_asid_i,
	input  wire                          inv_all_i,
	input  wire                          inv_i,
	input  wire  [mmu_pkg::VADDR_W-1:0]  inv_adr_i,
	input  wire  [mmu_pkg::ASID_W-1:0]   inv_asid_i,
	input  wire                          fill_i,
	input  wire  [mmu_pkg::PPN_W-1:0]    fill_ppn_i,
	input  wire  [mmu_pkg::FLAG_W-1:0]   fill_flags_i,
	output logic                         hit_o,
	output logic                         miss_o,
	output logic [mmu_pkg::PPN_W-1:0]    hit_ppn_o,
	output logic [mmu_pkg::FLAG_W-1:0]   hit_flags_o
);

	localparam int SEL_W = $clog2(TLB_ENTRIES);

	logic [TLB_ENTRIES-1:0]       ent_valid;
	logic [mmu_pkg::ASID_W-1:0]   ent_asid [TLB_ENTRIES];
	logic [mmu_pkg::VPN_W-1:0]    ent_vpn [TLB_ENTRIES];
	logic [mmu_pkg::PPN_W-1:0]    ent_ppn [TLB_ENTRIES];
	logic [mmu_pkg::FLAG_W-1:0]   ent_flags [TLB_ENTRIES];
	logic [TLB_ENTRIES-1:0]       match;
	logic [TLB_ENTRIES-1:0]       inv_match;
	logic [SEL_W-1:0]             hit_sel;
	logic [SEL_W-1:0]             victim;	// round-robin pointer

	always_comb begin
		hit_sel = '0;
		for (int i = 0; i < TLB_ENTRIES; i++) begin
			match[i] = ent_valid[i] && ent_asid[i] == req_asid_i && ent_vpn[i] == req_vpn_i;
			inv_match[i] = ent_valid[i] && ent_asid[i] == inv_asid_i
				&& ent_vpn[i] == inv_adr_i[mmu_pkg::VADDR_W-1:mmu_pkg::PAGE_OFS_W];
			if (match[i])
				hit_sel = SEL_W'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ent_valid <= '0;
			victim    <= '0;
			hit_o     <= 1'b0;
			miss_o    <= 1'b0;
		end else begin
			hit_o  <= (req_valid_i && |match) || fill_i;	// a fill answers as a hit
			miss_o <= req_valid_i && !(|match);
			if (fill_i) begin
				ent_valid[victim] <= 1'b1;
				victim            <= victim + 1'b1;
			end
			if (inv_all_i)
				ent_valid <= '0;
			else if (inv_i)
				ent_valid <= ent_valid & ~inv_match;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_i) begin
			ent_asid[victim]  <= req_asid_i;
			ent_vpn[victim]   <= req_vpn_i;
			ent_ppn[victim]   <= fill_ppn_i;
			ent_flags[victim] <= fill_flags_i;
			hit_ppn_o         <= fill_ppn_i;
			hit_flags_o       <= fill_flags_i;
		end else begin
			hit_ppn_o   <= ent_ppn[hit_sel];
			hit_flags_o <= ent_flags[hit_sel];
		end
	end

	a_single_match: assert property (
		@(posedge clk) disable iff (rst)
		req_valid_i |-> $onehot0(match)
	);

endmodule

`default_nettype wire

// ==== mmu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module mmu_top #(
	parameter int TLB_ENTRIES  = 8,
	parameter int WALK_TIMEOUT = 255
) (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          cyc_i,
	input  wire                          stb_i,
	input  wire                          we_i,
	input  wire                          icl_i,
	input  wire  [mmu_pkg::OL_W-1:0]     ol_i,
	input  wire  [mmu_pkg::ASID_W-1:0]   asid_i,
	input  wire  [mmu_pkg::VADDR_W-1:0]  vadr_i,
	output logic                         ack_o,
	output logic [mmu_pkg::VADDR_W-1:0]  padr_o,
	output logic                         cac_o,
	output logic                         page_fault_o,
	output logic                         prv_o,
	output logic                         exv_o,
	output logic                         rdv_o,
	output logic                         wrv_o,
	input  wire                          inv_all_i,
	input  wire                          inv_i,
	input  wire  [mmu_pkg::VADDR_W-1:0]  inv_adr_i,
	input  wire  [mmu_pkg::VADDR_W-1:0]  pta_i,
	output logic                         mem_cyc_o,
	output logic                         mem_stb_o,
	output logic [mmu_pkg::VADDR_W-1:0]  mem_adr_o,
	input  wire  [31:0]                  mem_dat_i,
	input  wire                          mem_ack_i
);

	logic                        busy;
	logic                        req_valid;
	logic [mmu_pkg::VPN_W-1:0]   req_vpn;
	logic [mmu_pkg::ASID_W-1:0]  req_asid;
	mmu_pkg::acc_kind_e          req_kind;
	logic                        hit;
	logic                        miss;
	logic [mmu_pkg::PPN_W-1:0]   hit_ppn;
	logic [mmu_pkg::FLAG_W-1:0]  hit_flags;
	logic                        fill;
	logic [mmu_pkg::PPN_W-1:0]   fill_ppn;
	logic [mmu_pkg::FLAG_W-1:0]  fill_flags;
	logic                        fault;

	mmu_req_decode mmu_req_decode_i (
		.clk         (clk),
		.rst         (rst),
		.cyc_i       (cyc_i),
		.stb_i       (stb_i),
		.we_i        (we_i),
		.icl_i       (icl_i),
		.vadr_i      (vadr_i),
		.asid_i      (asid_i),
		.busy_i      (busy),
		.req_valid_o (req_valid),
		.req_vpn_o   (req_vpn),
		.req_asid_o  (req_asid),
		.req_kind_o  (req_kind)
	);

	mmu_tlb #(
		.TLB_ENTRIES (TLB_ENTRIES)
	) mmu_tlb_i (
		.clk          (clk),
		.rst          (rst),
		.req_valid_i  (req_valid),
		.req_vpn_i    (req_vpn),
		.req_asid_i   (req_asid),
		.inv_all_i    (inv_all_i),
		.inv_i        (inv_i),
		.inv_adr_i    (inv_adr_i),
		.inv_asid_i   (asid_i),
		.fill_i       (fill),
		.fill_ppn_i   (fill_ppn),
		.fill_flags_i (fill_flags),
		.hit_o        (hit),
		.miss_o       (miss),
		.hit_ppn_o    (hit_ppn),
		.hit_flags_o  (hit_flags)
	);

	mmu_table_walk #(
		.WALK_TIMEOUT (WALK_TIMEOUT)
	) mmu_table_walk_i (
		.clk          (clk),
		.rst          (rst),
		.miss_i       (miss),
		.vpn_i        (req_vpn),
		.pta_i        (pta_i),
		.mem_ack_i    (mem_ack_i),
		.mem_dat_i    (mem_dat_i),
		.mem_cyc_o    (mem_cyc_o),
		.mem_stb_o    (mem_stb_o),
		.mem_adr_o    (mem_adr_o),
		.fill_o       (fill),
		.fill_ppn_o   (fill_ppn),
		.fill_flags_o (fill_flags),
		.fault_o      (fault)
	);

	mmu_access_check mmu_access_check_i (
		.clk          (clk),
		.rst          (rst),
		.hit_i        (hit),
		.ppn_i        (hit_ppn),
		.flags_i      (hit_flags),
		.fault_i      (fault),
		.kind_i       (req_kind),
		.ol_i         (ol_i),
		.ofs_i        (vadr_i[mmu_pkg::PAGE_OFS_W-1:0]),	// cpu holds the address
		.stb_i        (stb_i),
		.ack_o        (ack_o),
		.busy_o       (busy),
		.padr_o       (padr_o),
		.cac_o        (cac_o),
		.page_fault_o (page_fault_o),
		.prv_o        (prv_o),
		.exv_o        (exv_o),
		.rdv_o        (rdv_o),
		.wrv_o        (wrv_o)
	);

endmodule

`default_nettype wire

// ==== tb_mmu.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mmu;

	localparam int ACK_MAX  = 50;
	localparam int IDLE_MAX = 10000;	// table load takes about 4k cycles

	typedef struct packed {
		logic [31:0] padr;
		logic        cac;
		logic        pf;
		logic        prv;
		logic        exv;
		logic        rdv;
		logic        wrv;
		logic        chk_lat;	// expect a 3 cycle hit
	} exp_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        cyc_i, stb_i, we_i, icl_i;
	logic [2:0]  ol_i;
	logic [7:0]  asid_i;
	logic [31:0] vadr_i, inv_adr_i, pta_i;
	logic        inv_all_i, inv_i;
	logic        ack_o, cac_o, page_fault_o, prv_o, exv_o, rdv_o, wrv_o;
	logic [31:0] padr_o;
	logic        mem_cyc, mem_stb, mem_ack;
	logic [31:0] mem_adr, mem_dat;
	logic        wr_en;
	logic [11:0] wr_idx;
	logic [31:0] wr_dat;

	logic [31:0] tbl [4096];	// copy of the memory model
	exp_t        exp_q [$];
	int          checked_cnt = 0;
	int          err_cnt = 0;
	integer      seed = 32'hb12ef4e8;

	always #5 clk = ~clk;

	mmu_top #(
		.TLB_ENTRIES  (8),
		.WALK_TIMEOUT (255)
	) mmu_top_i (
		.clk (clk), .rst (rst),
		.cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i), .icl_i (icl_i),
		.ol_i (ol_i), .asid_i (asid_i), .vadr_i (vadr_i),
		.ack_o (ack_o), .padr_o (padr_o), .cac_o (cac_o),
		.page_fault_o (page_fault_o), .prv_o (prv_o), .exv_o (exv_o),
		.rdv_o (rdv_o), .wrv_o (wrv_o),
		.inv_all_i (inv_all_i), .inv_i (inv_i), .inv_adr_i (inv_adr_i), .pta_i (pta_i),
		.mem_cyc_o (mem_cyc), .mem_stb_o (mem_stb), .mem_adr_o (mem_adr),
		.mem_dat_i (mem_dat), .mem_ack_i (mem_ack)
	);

	tb_mmu_mem tb_mmu_mem_i (
		.clk (clk), .rst (rst),
		.cyc_i (mem_cyc), .stb_i (mem_stb), .adr_i (mem_adr),
		.wr_en_i (wr_en), .wr_idx_i (wr_idx), .wr_dat_i (wr_dat),
		.dat_o (mem_dat), .ack_o (mem_ack)
	);

	function automatic logic [31:0] pta_of(input logic [7:0] asid);
		return (asid == 8'd2) ? 32'h0000_2000 : 32'h0000_0000;	// asid 2 has its own tables
	endfunction

	function automatic logic [31:0] make_va(input int i1, input int i2, input int ofs);
		return {i1[9:0], i2[9:0], ofs[11:0]};
	endfunction

	// flags ordered c u x w r, then leaf and valid
	function automatic logic [31:0] leaf_word(input logic [31:0] ppn, input logic [4:0] fl);
		return {ppn[19:0], 5'b0, fl, 2'b11};
	endfunction

	function automatic logic [31:0] dir_word(input logic [19:0] ptn);
		return {ptn, 10'b0, 2'b01};
	endfunction

	// two-level walk over the copy, memory wraps at 16 KiB
	function automatic exp_t ref_translate(input logic [7:0] asid, input logic [31:0] va,
			input logic we, input logic icl, input logic [2:0] ol);
		logic [31:0] a1, a2, l1, l2;
		exp_t        e;
		e  = '0;
		a1 = pta_of(asid) + {20'b0, va[31:22], 2'b00};
		l1 = tbl[a1[13:2]];
		a2 = {l1[31:12], va[21:12], 2'b00};
		l2 = tbl[a2[13:2]];
		if (!l1[0] || l1[1] || !l2[0] || !l2[1]) begin
			e.pf = 1'b1;	// no superpages, leaf needed at level two
		end else begin
			e.padr = {l2[31:12], va[11:0]};
			e.cac  = l2[6];
			e.prv  = (ol != 3'd0) && !l2[5];
			e.exv  = icl && !l2[4];
			e.wrv  = !icl && we && !l2[3];
			e.rdv  = !icl && !we && !l2[2];
		end
		return e;
	endfunction

	task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			err_cnt++;
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic write_word(input int idx, input logic [31:0] dat);
		tbl[idx] = dat;
		@(posedge clk);
		wr_en  <= 1'b1;
		wr_idx <= idx[11:0];
		wr_dat <= dat;
	endtask

	task automatic end_writes;
		@(posedge clk);
		wr_en <= 1'b0;
	endtask

	task automatic pulse_inv_all;
		@(posedge clk);
		inv_all_i <= 1'b1;
		@(posedge clk);
		inv_all_i <= 1'b0;
	endtask

	task automatic pulse_inv_page(input logic [7:0] asid, input logic [31:0] va);
		@(posedge clk);
		inv_i     <= 1'b1;
		inv_adr_i <= va;
		asid_i    <= asid;
		@(posedge clk);
		inv_i <= 1'b0;
	endtask

	task automatic run_req(input logic [7:0] asid, input logic [31:0] va, input logic we,
			input logic icl, input logic [2:0] ol, input logic chk_lat);
		exp_t e;
		int   start;
		int   n;
		e = ref_translate(asid, va, we, icl, ol);
		e.chk_lat = chk_lat;
		@(posedge clk);
		exp_q.push_back(e);
		start  = checked_cnt;
		cyc_i  <= 1'b1;
		stb_i  <= 1'b1;
		asid_i <= asid;
		vadr_i <= va;
		we_i   <= we;
		icl_i  <= icl;
		ol_i   <= ol;
		pta_i  <= pta_of(asid);
		n = 0;
		while (checked_cnt == start) begin
			@(posedge clk);
			n++;
			if (n > ACK_MAX + 10)
				stop_on_timeout("the result check");
		end
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > ACK_MAX)
				stop_on_timeout("ack_o to fall");
		end while (ack_o);
	endtask

	initial begin : compare_proc
		exp_t e;
		int   idle;
		int   lat;
		forever begin
			idle = 0;
			while (exp_q.size() == 0) begin
				@(negedge clk);
				idle++;
				if (idle > IDLE_MAX)
					stop_on_timeout("a request");
			end
			e   = exp_q.pop_front();
			lat = 0;
			while (!ack_o) begin
				@(negedge clk);
				lat++;
				if (lat > ACK_MAX)
					stop_on_timeout("ack_o");
			end
			if (e.chk_lat)
				check_val("hit latency", 32'(lat), 32'd3);
			check_val("padr_o", padr_o, e.padr);
			check_val("cac_o", 32'(cac_o), 32'(e.cac));
			check_val("page_fault_o", 32'(page_fault_o), 32'(e.pf));
			check_val("prv_o", 32'(prv_o), 32'(e.prv));
			check_val("exv_o", 32'(exv_o), 32'(e.exv));
			check_val("rdv_o", 32'(rdv_o), 32'(e.rdv));
			check_val("wrv_o", 32'(wrv_o), 32'(e.wrv));
			check_val("mem_cyc_o", 32'(mem_cyc), 32'd0);	// walk is over by the ack
			check_val("mem_stb_o", 32'(mem_stb), 32'd0);
			checked_cnt++;
		end
	end

	initial begin : stimulus
		logic [31:0] rnd;
		logic [31:0] va;
		rst = 1'b1;
		{cyc_i, stb_i, we_i, icl_i, inv_all_i, inv_i, wr_en} = '0;
		ol_i = '0;
		asid_i = '0;
		{vadr_i, inv_adr_i, pta_i, wr_dat} = '0;
		wr_idx = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		for (int i = 0; i < 4096; i++)
			write_word(i, $random(seed));
		// asid 1: level one at page 0, level two at page 1
		write_word(1, dir_word(20'd1));
		write_word(2, 32'h0);
		write_word(3, 32'h0000_5003);	// level one leaf
		write_word(4, dir_word(20'd1));
		write_word(1024 + 5, leaf_word($random(seed), 5'b11001));
		write_word(1024 + 6, 32'h0);
		write_word(1024 + 7, 32'h0000_0001);	// valid pointer at level two
		write_word(1024 + 8, leaf_word($random(seed), 5'b00101));	// supervisor only
		write_word(1024 + 9, leaf_word($random(seed), 5'b01010));
		write_word(1024 + 10, leaf_word($random(seed), 5'b10111));
		// asid 2: level one at page 2, level two at page 3
		write_word(2048 + 4, dir_word(20'd3));
		write_word(3072 + 10, leaf_word($random(seed), 5'b01011));
		end_writes();

		run_req(8'd1, make_va(1, 5, 'h123), 1'b0, 1'b0, 3'd3, 1'b0);
		run_req(8'd1, make_va(1, 5, 'h7fc), 1'b0, 1'b0, 3'd3, 1'b1);
		run_req(8'd1, make_va(2, 0, 'h010), 1'b0, 1'b0, 3'd0, 1'b0);
		run_req(8'd1, make_va(3, 0, 'h010), 1'b0, 1'b0, 3'd0, 1'b0);
		run_req(8'd1, make_va(1, 6, 'h010), 1'b0, 1'b0, 3'd0, 1'b0);
		run_req(8'd1, make_va(1, 7, 'h010), 1'b1, 1'b0, 3'd0, 1'b0);
		run_req(8'd1, make_va(1, 8, 'h020), 1'b0, 1'b1, 3'd3, 1'b0);
		run_req(8'd1, make_va(1, 8, 'h020), 1'b0, 1'b1, 3'd0, 1'b0);
		run_req(8'd1, make_va(1, 8, 'h020), 1'b1, 1'b0, 3'd0, 1'b0);
		run_req(8'd1, make_va(1, 9, 'h030), 1'b0, 1'b1, 3'd2, 1'b0);
		run_req(8'd1, make_va(1, 9, 'h030), 1'b0, 1'b0, 3'd2, 1'b0);
		run_req(8'd1, make_va(1, 9, 'h030), 1'b1, 1'b0, 3'd2, 1'b0);
		run_req(8'd1, make_va(1, 9, 'h030), 1'b1, 1'b1, 3'd2, 1'b0);	// fetch wins
		run_req(8'd1, make_va(4, 10, 'h444), 1'b0, 1'b0, 3'd1, 1'b0);
		run_req(8'd2, make_va(4, 10, 'h444), 1'b0, 1'b0, 3'd1, 1'b0);

		// remap asid 2 only, asid 1 must still hit
		write_word(3072 + 10, leaf_word($random(seed), 5'b11111));
		end_writes();
		pulse_inv_page(8'd2, make_va(4, 10, 0));
		run_req(8'd2, make_va(4, 10, 'h444), 1'b0, 1'b0, 3'd1, 1'b0);
		run_req(8'd1, make_va(4, 10, 'h444), 1'b0, 1'b0, 3'd1, 1'b1);

		write_word(1024 + 5, leaf_word($random(seed), 5'b01111));
		end_writes();
		pulse_inv_all();
		run_req(8'd1, make_va(1, 5, 'h123), 1'b0, 1'b0, 3'd3, 1'b0);

		for (int i = 0; i < 40; i++) begin
			rnd = $random(seed);
			va  = $random(seed);
			if (rnd[1])
				va[31:22] = 10'd1;	// steer into the asid 1 tables
			run_req(rnd[0] ? 8'd2 : 8'd1, va, rnd[5], rnd[6], rnd[4:2], 1'b0);
		end

		if (err_cnt == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb_mmu_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_mmu_mem (
	input  wire         clk,
	input  wire         rst,
	input  wire         cyc_i,
	input  wire         stb_i,
	input  wire  [31:0] adr_i,
	input  wire         wr_en_i,	// loader port, used between requests
	input  wire  [11:0] wr_idx_i,
	input  wire  [31:0] wr_dat_i,
	output logic [31:0] dat_o,
	output logic        ack_o
);

	logic [31:0] mem [4096];	// 16 KiB, upper address bits ignored

	always_ff @(posedge clk) begin
		if (rst) begin
			ack_o <= 1'b0;
		end else begin
			ack_o <= cyc_i && stb_i && !ack_o;	// one cycle after strobe
		end
	end

	always_ff @(posedge clk) begin
		dat_o <= mem[adr_i[13:2]];
		if (wr_en_i)
			mem[wr_idx_i] <= wr_dat_i;
	end

endmodule

`default_nettype wire
